/* backdoorExec.sv */
// Backdoor access engine
`timescale 1ns/1ps

module backdoorExec (
  input  logic                clk,
  input  logic                reset_i,
  input  dvtPkg::memReq_t     memReq_i,
  output logic                memDone_o,
  output dvtPkg::word64_t     memRdata_o,
  // Scratchpad port
  output logic                spWrite_o,
  output memPkg::mainAddr_t   spAddr_o,
  output dvtPkg::word64_t     spWdata_o,
  input  dvtPkg::word64_t     spRdata_i,
  // Flash port
  output logic                flWrite_o,
  output memPkg::flashAddr_t  flAddr_o,
  output memPkg::byteData_t   flWdata_o,
  input  memPkg::byteData_t   flRdata_i
);

  typedef enum logic [1:0] {
    IDLE,
    MAIN_ACCESS,
    MAIN_WAIT,
    FLASH_BYTES
  } execState_t;

  execState_t        state;
  memPkg::byteCnt_t  byteCnt;
  logic              flashLast;
  logic              reqWrite;
  dvtPkg::byteAddr_t reqAddr;
  dvtPkg::word64_t   reqData;
  dvtPkg::word64_t   rdBuf;

  // ----------------------------------------
  // Memory drive
  // ----------------------------------------
  always_comb begin
    // Reads need one more step for the last registered byte
    flashLast = reqWrite ? (byteCnt == memPkg::byteCnt_t'(memPkg::BYTES_PER_WORD - 1))
                         : (byteCnt == memPkg::byteCnt_t'(memPkg::BYTES_PER_WORD));

    spWrite_o = (state == MAIN_ACCESS) && reqWrite;
    // Word index, low byte bits dropped
    spAddr_o  = memPkg::mainAddr_t'(reqAddr >> $clog2(memPkg::BYTES_PER_WORD));
    spWdata_o = reqData;

    flWrite_o = (state == FLASH_BYTES) && reqWrite;
    // 11-bit sum wraps modulo flash size
    flAddr_o  = memPkg::flashAddr_t'(reqAddr) + memPkg::flashAddr_t'(byteCnt);
    // Little-endian: byte i is data[8i +: 8]
    flWdata_o = memPkg::byteData_t'(reqData >> (8 * byteCnt));

    memDone_o = ((state == MAIN_ACCESS) && reqWrite) ||
                (state == MAIN_WAIT) ||
                ((state == FLASH_BYTES) && flashLast);

    if (reqWrite) begin
      memRdata_o = '0;
    end else if (state == MAIN_WAIT) begin
      memRdata_o = spRdata_i;
    end else begin
      // top byte arrives in the done cycle
      memRdata_o = {flRdata_i, rdBuf[55:0]};
    end
  end

  // ----------------------------------------
  // FSM
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset_i) begin
      state   <= IDLE;
      byteCnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          byteCnt <= '0;
          if (memReq_i.start) begin
            state <= memReq_i.toFlash ? FLASH_BYTES : MAIN_ACCESS;
          end
        end
        MAIN_ACCESS: state <= reqWrite ? IDLE : MAIN_WAIT;
        MAIN_WAIT:   state <= IDLE;
        FLASH_BYTES: begin
          if (flashLast) begin
            state <= IDLE;
          end else begin
            byteCnt <= byteCnt + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Request capture and read byte assembly
  always_ff @(posedge clk) begin
    if ((state == IDLE) && memReq_i.start) begin
      reqWrite <= memReq_i.isWrite;
      reqAddr  <= memReq_i.addr;
      reqData  <= memReq_i.data;
    end
    // Byte n-1 is on the read port at count n
    if ((state == FLASH_BYTES) && !reqWrite && (byteCnt != '0)) begin
      rdBuf[8 * (byteCnt - 1) +: 8] <= flRdata_i;
    end
  end

endmodule

/* dvtCmdDecode.sv */
// Debug command decoder
`timescale 1ns/1ps

module dvtCmdDecode (
  input  logic             clk,
  input  logic             reset_i,
  input  logic             cmdValid_i,
  input  dvtPkg::dvtCmd_t  cmd_i,
  input  logic             memDone_i,
  output logic             busy_o,
  output dvtPkg::memReq_t  memReq_o,
  output dvtPkg::dvtResp_t flagResp_o,
  output logic             chipReset_o,
  output logic             backdoorSel_o,
  output logic             programLoaded_o
);

  dvtPkg::flagVec_t  flags;
  dvtPkg::flagVec_t  rangeMask;
  dvtPkg::flagVec_t  flagsMerged;
  dvtPkg::flagVec_t  flagsNext;
  dvtPkg::word64_t   rangeValue;
  dvtPkg::resetCnt_t resetCnt;
  logic [8:0]        rangeWidth;
  logic              accept;
  logic              isFlagOp;
  logic              flagWrite;
  logic              setBackdoor;
  logic              getBackdoor;
  logic              setLoaded;
  logic              pulseReset;
  logic              selNext;
  // Request and response registers
  logic              reqStart;
  logic              reqWrite;
  logic              reqFlash;
  dvtPkg::byteAddr_t reqAddr;
  dvtPkg::word64_t   reqData;
  logic              respValid;
  dvtPkg::word64_t   respData;

  // ----------------------------------------
  // Range decode and action detection
  // ----------------------------------------
  always_comb begin
    accept    = cmdValid_i && !busy_o;
    isFlagOp  = (cmd_i.op == dvtPkg::OP_WRITE_FLAGS) || (cmd_i.op == dvtPkg::OP_READ_FLAGS);
    flagWrite = accept && (cmd_i.op == dvtPkg::OP_WRITE_FLAGS);

    // Ones over msb down to lsb
    rangeWidth  = {1'b0, cmd_i.msb} - {1'b0, cmd_i.lsb} + 9'd1;
    rangeMask   = ((dvtPkg::flagVec_t'(1) << rangeWidth) - dvtPkg::flagVec_t'(1)) << cmd_i.lsb;
    flagsMerged = (flags & ~rangeMask) |
                  ((dvtPkg::flagVec_t'(cmd_i.data) << cmd_i.lsb) & rangeMask);
    // Read value is right-justified, zero-filled
    rangeValue  = dvtPkg::word64_t'((flags & rangeMask) >> cmd_i.lsb);

    // Action bits act on the value being written
    setBackdoor = flagWrite && flagsMerged[dvtPkg::FLAG_SET_BACKDOOR];
    getBackdoor = flagWrite && flagsMerged[dvtPkg::FLAG_GET_BACKDOOR];
    setLoaded   = flagWrite && flagsMerged[dvtPkg::FLAG_SET_LOADED];
    pulseReset  = flagWrite && flagsMerged[dvtPkg::FLAG_CHIP_RESET];
    selNext     = setBackdoor ? flagsMerged[dvtPkg::FLAG_PAT_LO] : backdoorSel_o;

    flagsNext = flags;
    if (flagWrite) begin
      flagsNext = flagsMerged;
      // Action bits read back as zero once handled
      flagsNext[dvtPkg::FLAG_SET_BACKDOOR] = 1'b0;
      flagsNext[dvtPkg::FLAG_GET_BACKDOOR] = 1'b0;
      flagsNext[dvtPkg::FLAG_SET_LOADED]   = 1'b0;
      flagsNext[dvtPkg::FLAG_CHIP_RESET]   = 1'b0;
      if (getBackdoor) begin
        // Pattern field reports the select, zero-extended
        flagsNext[dvtPkg::FLAG_PAT_HI:dvtPkg::FLAG_PAT_LO] = '0;
        flagsNext[dvtPkg::FLAG_PAT_LO] = selNext;
      end
    end
  end

  // ----------------------------------------
  // Control state
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset_i) begin
      flags           <= '0;
      busy_o          <= 1'b0;
      reqStart        <= 1'b0;
      respValid       <= 1'b0;
      resetCnt        <= '0;
      backdoorSel_o   <= 1'b0;
      programLoaded_o <= 1'b0;
    end else begin
      flags         <= flagsNext;
      backdoorSel_o <= selNext;
      if (setLoaded) begin
        programLoaded_o <= flagsMerged[dvtPkg::FLAG_PAT_LO];
      end
      // Down-counter, a new write restarts the pulse
      if (pulseReset) begin
        resetCnt <= dvtPkg::resetCnt_t'(dvtPkg::CHIP_RESET_CYCLES);
      end else if (resetCnt != '0) begin
        resetCnt <= resetCnt - 1'b1;
      end
      reqStart  <= accept && !isFlagOp;
      respValid <= accept && isFlagOp;
      // Busy drops on the cycle the result stage fires
      if (accept) begin
        busy_o <= 1'b1;
      end else if (respValid || memDone_i) begin
        busy_o <= 1'b0;
      end
    end
  end

  // Payload, only meaningful alongside its strobe
  always_ff @(posedge clk) begin
    if (accept) begin
      reqWrite <= (cmd_i.op == dvtPkg::OP_WRITE64);
      reqFlash <= backdoorSel_o;
      reqAddr  <= cmd_i.addr;
      reqData  <= cmd_i.data;
      respData <= flagWrite ? '0 : rangeValue;
    end
  end

  assign chipReset_o = (resetCnt != '0);

  always_comb begin
    memReq_o.start   = reqStart;
    memReq_o.isWrite = reqWrite;
    memReq_o.toFlash = reqFlash;
    memReq_o.addr    = reqAddr;
    memReq_o.data    = reqData;
    flagResp_o.valid = respValid;
    flagResp_o.data  = respData;
  end

endmodule

/* dvtCtrlTop.sv */
// Debug controller top level
`timescale 1ns/1ps

module dvtCtrlTop (
  input  logic             clk,
  input  logic             reset_i,
  input  logic             cmdValid_i,
  input  dvtPkg::dvtCmd_t  cmd_i,
  output logic             busy_o,
  output dvtPkg::dvtResp_t resp_o,
  output logic             chipReset_o,
  output logic             backdoorSel_o,
  output logic             programLoaded_o
);

  // ----------------------------------------
  // Internal links
  // ----------------------------------------
  dvtPkg::memReq_t    memReq;
  dvtPkg::dvtResp_t   flagResp;
  logic               memDone;
  dvtPkg::word64_t    memRdata;
  // Scratchpad
  logic               spWrite;
  memPkg::mainAddr_t  spAddr;
  dvtPkg::word64_t    spWdata;
  dvtPkg::word64_t    spRdata;
  // Flash
  logic               flWrite;
  memPkg::flashAddr_t flAddr;
  memPkg::byteData_t  flWdata;
  memPkg::byteData_t  flRdata;

  dvtCmdDecode u_cmdDecode (
    .clk             (clk),
    .reset_i         (reset_i),
    .cmdValid_i      (cmdValid_i),
    .cmd_i           (cmd_i),
    .memDone_i       (memDone),
    .busy_o          (busy_o),
    .memReq_o        (memReq),
    .flagResp_o      (flagResp),
    .chipReset_o     (chipReset_o),
    .backdoorSel_o   (backdoorSel_o),
    .programLoaded_o (programLoaded_o)
  );

  backdoorExec u_backdoorExec (
    .clk        (clk),
    .reset_i    (reset_i),
    .memReq_i   (memReq),
    .memDone_o  (memDone),
    .memRdata_o (memRdata),
    .spWrite_o  (spWrite),
    .spAddr_o   (spAddr),
    .spWdata_o  (spWdata),
    .spRdata_i  (spRdata),
    .flWrite_o  (flWrite),
    .flAddr_o   (flAddr),
    .flWdata_o  (flWdata),
    .flRdata_i  (flRdata)
  );

  dvtResult u_result (
    .clk        (clk),
    .reset_i    (reset_i),
    .flagResp_i (flagResp),
    .memDone_i  (memDone),
    .memRdata_i (memRdata),
    .resp_o     (resp_o)
  );

  // Backdoor writes are always full words
  scratchpadRam u_scratchpadRam (
    .clk     (clk),
    .write_i (spWrite),
    .mask_i  ('1),
    .addr_i  (spAddr),
    .wdata_i (spWdata),
    .rdata_o (spRdata)
  );

  sdFlashRam u_sdFlashRam (
    .clk     (clk),
    .write_i (flWrite),
    .addr_i  (flAddr),
    .wdata_i (flWdata),
    .rdata_o (flRdata)
  );

endmodule

/* dvtCtrl_tb.sv */
// Debug controller testbench
`timescale 1ns/1ps

module dvtCtrl_tb;

  // One command with its expected outcome
  typedef struct packed {
    dvtPkg::dvtOp_t    op;
    dvtPkg::flagIdx_t  msb;
    dvtPkg::flagIdx_t  lsb;
    dvtPkg::byteAddr_t addr;
    dvtPkg::word64_t   data;
    dvtPkg::word64_t   expData;
    logic              expSel;
    logic              expLoaded;
    logic              pulse;
    int                latency;
  } tableRow_t;

  logic              clk;
  logic              reset_i;
  logic              cmdValid;
  dvtPkg::dvtCmd_t   cmd;
  logic              busy;
  dvtPkg::dvtResp_t  resp;
  logic              chipReset;
  logic              backdoorSel;
  logic              programLoaded;
  // Reference model state
  dvtPkg::flagVec_t  refFlags;
  logic              refSel;
  logic              refLoaded;
  dvtPkg::word64_t   refMain [memPkg::MAIN_WORDS];
  memPkg::byteData_t refFlash [memPkg::FLASH_BYTES];
  tableRow_t         rows [$];
  int                resetLeft;
  logic              tableReady;

  tbClock u_tbClock (
    .clk_o (clk)
  );

  dvtCtrlTop u_dvtCtrlTop (
    .clk             (clk),
    .reset_i         (reset_i),
    .cmdValid_i      (cmdValid),
    .cmd_i           (cmd),
    .busy_o          (busy),
    .resp_o          (resp),
    .chipReset_o     (chipReset),
    .backdoorSel_o   (backdoorSel),
    .programLoaded_o (programLoaded)
  );

  // ----------------------------------------
  // Checking
  // ----------------------------------------
  task automatic stopRun();
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic checkValue(input string name, input logic [63:0] actual,
                            input logic [63:0] expected);
    assert (actual === expected) else begin
      $display("** Error: %s = %h, expected %h", name, actual, expected);
      stopRun();
    end
  endtask

  // Chip reset pulse is tracked every cycle across command boundaries
  task automatic advanceCycle();
    @(negedge clk);
    checkValue("chipReset_o", 64'(chipReset), 64'(resetLeft > 0));
    if (resetLeft > 0) begin
      resetLeft--;
    end
  endtask

  // ----------------------------------------
  // Reference model with one row per command
  // ----------------------------------------
  task automatic flagWriteRow(input int msb, input int lsb, input dvtPkg::word64_t value);
    tableRow_t row;
    int        i;
    row = '0;
    for (i = lsb; i <= msb; i++) begin
      refFlags[i] = value[i - lsb];
    end
    // Actions see the freshly written bits
    row.pulse = refFlags[dvtPkg::FLAG_CHIP_RESET];
    if (refFlags[dvtPkg::FLAG_SET_BACKDOOR]) begin
      refSel = refFlags[dvtPkg::FLAG_PAT_LO];
    end
    if (refFlags[dvtPkg::FLAG_SET_LOADED]) begin
      refLoaded = refFlags[dvtPkg::FLAG_PAT_LO];
    end
    if (refFlags[dvtPkg::FLAG_GET_BACKDOOR]) begin
      for (i = dvtPkg::FLAG_PAT_LO; i <= dvtPkg::FLAG_PAT_HI; i++) begin
        refFlags[i] = 1'b0;
      end
      refFlags[dvtPkg::FLAG_PAT_LO] = refSel;
    end
    for (i = dvtPkg::FLAG_SET_BACKDOOR; i <= dvtPkg::FLAG_CHIP_RESET; i++) begin
      refFlags[i] = 1'b0;
    end
    row.op        = dvtPkg::OP_WRITE_FLAGS;
    row.msb       = dvtPkg::flagIdx_t'(msb);
    row.lsb       = dvtPkg::flagIdx_t'(lsb);
    row.data      = value;
    row.expSel    = refSel;
    row.expLoaded = refLoaded;
    row.latency   = 2;
    rows.push_back(row);
  endtask

  task automatic flagReadRow(input int msb, input int lsb);
    tableRow_t row;
    int        i;
    row = '0;
    // Right-justified and zero above the range
    for (i = 0; i <= msb - lsb; i++) begin
      row.expData[i] = refFlags[lsb + i];
    end
    row.op        = dvtPkg::OP_READ_FLAGS;
    row.msb       = dvtPkg::flagIdx_t'(msb);
    row.lsb       = dvtPkg::flagIdx_t'(lsb);
    row.expSel    = refSel;
    row.expLoaded = refLoaded;
    row.latency   = 2;
    rows.push_back(row);
  endtask

  task automatic memWriteRow(input dvtPkg::byteAddr_t addr, input dvtPkg::word64_t data);
    tableRow_t          row;
    memPkg::flashAddr_t fa;
    int                 b;
    row = '0;
    if (refSel) begin
      // Little-endian bytes with the address wrapping at the flash size
      for (b = 0; b < memPkg::BYTES_PER_WORD; b++) begin
        fa = memPkg::flashAddr_t'(addr + dvtPkg::byteAddr_t'(b));
        refFlash[fa] = data[8*b +: 8];
      end
    end else begin
      refMain[memPkg::mainAddr_t'(addr >> 3)] = data;
    end
    row.op        = dvtPkg::OP_WRITE64;
    row.addr      = addr;
    row.data      = data;
    row.expSel    = refSel;
    row.expLoaded = refLoaded;
    row.latency   = refSel ? 10 : 3;
    rows.push_back(row);
  endtask

  task automatic memReadRow(input dvtPkg::byteAddr_t addr);
    tableRow_t          row;
    memPkg::flashAddr_t fa;
    int                 b;
    row = '0;
    if (refSel) begin
      for (b = 0; b < memPkg::BYTES_PER_WORD; b++) begin
        fa = memPkg::flashAddr_t'(addr + dvtPkg::byteAddr_t'(b));
        row.expData[8*b +: 8] = refFlash[fa];
      end
    end else begin
      row.expData = refMain[memPkg::mainAddr_t'(addr >> 3)];
    end
    row.op        = dvtPkg::OP_READ64;
    row.addr      = addr;
    row.expSel    = refSel;
    row.expLoaded = refLoaded;
    row.latency   = refSel ? 11 : 4;
    rows.push_back(row);
  endtask

  // ----------------------------------------
  // Command driver
  // ----------------------------------------
  task automatic applyRow(input tableRow_t row);
    dvtPkg::dvtCmd_t c;
    int              k;
    c.op   = row.op;
    c.msb  = row.msb;
    c.lsb  = row.lsb;
    c.addr = row.addr;
    c.data = row.data;
    @(posedge clk);
    cmdValid <= 1'b1;
    cmd      <= c;
    advanceCycle();
    // Acceptance cycle with the previous command fully retired
    checkValue("busy_o", 64'(busy), 64'd0);
    checkValue("resp_o.valid", 64'(resp.valid), 64'd0);
    if (row.pulse) begin
      resetLeft = dvtPkg::CHIP_RESET_CYCLES;
    end
    @(posedge clk);
    cmdValid <= 1'b0;
    // Exactly one valid pulse and busy until then
    for (k = 1; k <= row.latency; k++) begin
      advanceCycle();
      checkValue("resp_o.valid", 64'(resp.valid), 64'(k == row.latency));
      checkValue("busy_o", 64'(busy), 64'(k != row.latency));
    end
    checkValue("resp_o.data", resp.data, row.expData);
    checkValue("backdoorSel_o", 64'(backdoorSel), 64'(row.expSel));
    checkValue("programLoaded_o", 64'(programLoaded), 64'(row.expLoaded));
  endtask

  // ----------------------------------------
  // Stimulus table and run
  // ----------------------------------------
  initial begin
    int                i;
    int                lsb;
    int                msb;
    dvtPkg::byteAddr_t a;
    void'($urandom(32'hf3ed7b39));
    reset_i    = 1'b1;
    cmdValid   = 1'b0;
    cmd        = '0;
    resetLeft  = 0;
    tableReady = 1'b0;
    refFlags   = '0;
    refSel     = 1'b0;
    refLoaded  = 1'b0;

    // Pattern field and then random ranges clear of the action bits
    flagWriteRow(31, 0, {$urandom, $urandom});
    flagReadRow(31, 0);
    flagReadRow(15, 4);
    for (i = 0; i < 6; i++) begin
      lsb = 48 + int'($urandom % 208);
      msb = lsb + int'($urandom % 64);
      if (msb > 255) begin
        msb = 255;
      end
      flagWriteRow(msb, lsb, {$urandom, $urandom});
      flagReadRow(msb, lsb);
    end
    flagWriteRow(255, 192, {$urandom, $urandom});
    // Get backdoor with select low
    flagWriteRow(dvtPkg::FLAG_GET_BACKDOOR, dvtPkg::FLAG_GET_BACKDOOR, 64'd1);
    flagReadRow(31, 0);

    // Scratchpad words where the low three address bits alias
    for (i = 0; i < 4; i++) begin
      a = $urandom;
      memWriteRow(a, {$urandom, $urandom});
      memReadRow(a ^ ($urandom % 8));
    end
    memWriteRow(32'h0000_0105, {$urandom, $urandom});
    memReadRow(32'h8000_0100);

    // Switch to flash
    flagWriteRow(40, 0, (64'd1 << 40) | 64'd1);
    flagWriteRow(dvtPkg::FLAG_GET_BACKDOOR, dvtPkg::FLAG_GET_BACKDOOR, 64'd1);
    // Select and get bits both read back as zero
    flagReadRow(43, 40);
    flagReadRow(31, 0);
    a = $urandom;
    memWriteRow(a, {$urandom, $urandom});
    memReadRow(a);
    // Second word wraps to byte zero
    memWriteRow(32'd2040, {$urandom, $urandom});
    memWriteRow(32'd2048, {$urandom, $urandom});
    for (i = 1; i < 8; i++) begin
      memReadRow(32'd2040 + dvtPkg::byteAddr_t'(i));
    end
    memReadRow(32'hFFFF_FFFC);

    // Program loaded and chip reset
    flagWriteRow(42, 0, (64'd1 << 42) | 64'd1);
    flagReadRow(43, 40);
    flagWriteRow(dvtPkg::FLAG_CHIP_RESET, dvtPkg::FLAG_CHIP_RESET, 64'd1);
    flagReadRow(47, 40);
    memReadRow(32'd2040);
    flagWriteRow(42, 0, 64'd1 << 42);
    flagWriteRow(40, 0, 64'd1 << 40);
    memReadRow(32'h0000_0100);

    // Whole upper region to catch stray writes
    flagReadRow(111, 48);
    flagReadRow(175, 112);
    flagReadRow(239, 176);
    flagReadRow(255, 240);
    tableReady = 1'b1;

    repeat (5) @(posedge clk);
    reset_i <= 1'b0;
    advanceCycle();
    checkValue("busy_o", 64'(busy), 64'd0);
    checkValue("resp_o.valid", 64'(resp.valid), 64'd0);
    checkValue("backdoorSel_o", 64'(backdoorSel), 64'd0);
    checkValue("programLoaded_o", 64'(programLoaded), 64'd0);

    foreach (rows[n]) begin
      applyRow(rows[n]);
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    wait (tableReady === 1'b1);
    repeat (rows.size() * 20) @(posedge clk);
    $display("Timeout: the command table did not complete in time");
    stopRun();
  end

endmodule

/* dvtPkg.sv */
// Debug command types
package dvtPkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------
  localparam int FLAG_BITS = 256;
  localparam int WORD_BITS = 64;
  localparam int ADDR_BITS = 32;

  typedef logic [7:0]             flagIdx_t;
  typedef logic [FLAG_BITS-1:0]   flagVec_t;
  typedef logic [WORD_BITS-1:0]   word64_t;
  typedef logic [ADDR_BITS-1:0]   byteAddr_t;

  // ----------------------------------------
  // Flag map
  // ----------------------------------------
  // Pattern field carries arguments and results of the action bits
  localparam int FLAG_PAT_LO = 0;
  localparam int FLAG_PAT_HI = 31;

  // Action bits, cleared by hardware once handled
  localparam int FLAG_SET_BACKDOOR = 40;
  localparam int FLAG_GET_BACKDOOR = 41;
  localparam int FLAG_SET_LOADED   = 42;
  localparam int FLAG_CHIP_RESET   = 43;

  // Chip reset pulse length in clk cycles
  localparam int CHIP_RESET_CYCLES = 10;
  typedef logic [$clog2(CHIP_RESET_CYCLES + 1)-1:0] resetCnt_t;

  // ----------------------------------------
  // Commands and responses
  // ----------------------------------------
  typedef enum logic [1:0] {
    OP_WRITE_FLAGS = 2'd0,
    OP_READ_FLAGS  = 2'd1,
    OP_WRITE64     = 2'd2,
    OP_READ64      = 2'd3
  } dvtOp_t;

  // Host command; data holds flag value or write word
  typedef struct packed {
    dvtOp_t    op;
    flagIdx_t  msb;
    flagIdx_t  lsb;
    byteAddr_t addr;
    word64_t   data;
  } dvtCmd_t;

  // Decode to execute request
  typedef struct packed {
    logic      start;
    logic      isWrite;
    logic      toFlash;
    byteAddr_t addr;
    word64_t   data;
  } memReq_t;

  typedef struct packed {
    logic    valid;
    word64_t data;
  } dvtResp_t;

endpackage

/* dvtResult.sv */
// Command response register
`timescale 1ns/1ps

module dvtResult (
  input  logic             clk,
  input  logic             reset_i,
  input  dvtPkg::dvtResp_t flagResp_i,
  input  logic             memDone_i,
  input  dvtPkg::word64_t  memRdata_i,
  output dvtPkg::dvtResp_t resp_o
);

  logic            respValid;
  dvtPkg::word64_t respData;

  // ----------------------------------------
  // Valid pulse
  // ----------------------------------------
  // One command in flight, so at most one source fires per cycle
  always_ff @(posedge clk) begin
    if (reset_i) begin
      respValid <= 1'b0;
    end else begin
      respValid <= flagResp_i.valid || memDone_i;
    end
  end

  // Result data, memory writes already arrive as zero
  always_ff @(posedge clk) begin
    if (flagResp_i.valid) begin
      respData <= flagResp_i.data;
    end else if (memDone_i) begin
      respData <= memRdata_i;
    end
  end

  always_comb begin
    resp_o.valid = respValid;
    resp_o.data  = respData;
  end

endmodule

/* memPkg.sv */
// Backdoor memory geometry
package memPkg;

  // ----------------------------------------
  // Scratchpad, one 64-bit word per entry
  // ----------------------------------------
  localparam int MAIN_WORDS  = 256;
  localparam int MAIN_ADDR_W = 8;

  // ----------------------------------------
  // Flash, one byte per entry
  // ----------------------------------------
  localparam int FLASH_BYTES  = 2048;
  localparam int FLASH_ADDR_W = 11;

  // Bytes moved per backdoor word
  localparam int BYTES_PER_WORD = 8;

  typedef logic [MAIN_ADDR_W-1:0]  mainAddr_t;
  typedef logic [FLASH_ADDR_W-1:0] flashAddr_t;
  typedef logic [7:0]              byteData_t;

  // Counts 0..BYTES_PER_WORD, one extra step for the registered read
  typedef logic [$clog2(BYTES_PER_WORD):0] byteCnt_t;

endpackage

/* run.sh */
#!/bin/sh
# Compile with Verilator, run, then judge the log
rm -f sim.log
verilator --binary --timing --top-module dvtCtrl_tb -f sim.f -o dvtCtrl_sim \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/dvtCtrl_sim > sim.log 2>&1 || true
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1
grep -q "TESTBENCH PASSED" sim.log || exit 1
exit 0

/* scratchpadRam.sv */
// Scratchpad word memory
`timescale 1ns/1ps

module scratchpadRam (
  input  logic              clk,
  input  logic              write_i,
  input  dvtPkg::word64_t   mask_i,
  input  memPkg::mainAddr_t addr_i,
  input  dvtPkg::word64_t   wdata_i,
  output dvtPkg::word64_t   rdata_o
);

  dvtPkg::word64_t mem [memPkg::MAIN_WORDS];

  // ----------------------------------------
  // Masked write
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (write_i) begin
      // Only bits set in the mask take new data
      mem[addr_i] <= (mem[addr_i] & ~mask_i) | (wdata_i & mask_i);
    end
  end

  // ----------------------------------------
  // Registered read
  // ----------------------------------------
  // Returns old contents when read and write hit together
  always_ff @(posedge clk) begin
    rdata_o <= mem[addr_i];
  end

endmodule

/* sdFlashRam.sv */
// Flash byte memory model
`timescale 1ns/1ps

module sdFlashRam (
  input  logic               clk,
  input  logic               write_i,
  input  memPkg::flashAddr_t addr_i,
  input  memPkg::byteData_t  wdata_i,
  output memPkg::byteData_t  rdata_o
);

  memPkg::byteData_t mem [memPkg::FLASH_BYTES];

  // ----------------------------------------
  // Single byte port
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (write_i) begin
      mem[addr_i] <= wdata_i;
    end
    // Read data lags the address by one cycle
    rdata_o <= mem[addr_i];
  end

endmodule

/* sim.f */
dvtPkg.sv
memPkg.sv
scratchpadRam.sv
sdFlashRam.sv
dvtCmdDecode.sv
backdoorExec.sv
dvtResult.sv
dvtCtrlTop.sv
tbClock.sv
dvtCtrl_tb.sv

/* tbClock.sv */
// Testbench clock source
`timescale 1ns/1ps

module tbClock (
  output logic clk_o
);

  // ----------------------------------------
  // 8 ns period
  // ----------------------------------------
  // Starts low, first rising edge at 4 ns
  initial begin
    clk_o = 1'b0;
    forever begin
      #4 clk_o = ~clk_o;
    end
  end

endmodule
